//--- files.f
+incdir+include
rtl/conv_pkg.sv
rtl/frame_scanner.sv
rtl/line_buffer.sv
rtl/window_regs.sv
rtl/conv_engine.sv
rtl/conv_top.sv
verification/conv_checker.sv
verification/tb_conv_top.sv

//--- run.sh
#!/bin/sh
# Build and run the conv_top testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_conv_top -o tb_conv_top \
    && ./obj_dir/tb_conv_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/tb_conv_top.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module tb_conv_top;

    localparam int FRAME_PIX   = `CONV_IMG_W * `CONV_IMG_H;
    localparam int DRAIN_LIMIT = 8 * `CONV_IMG_W + 64;   // Cycles for flush and last outputs.
    localparam logic [`CONV_TAPS*`CONV_COEF_W-1:0] IDENT_KERN = 72'h00_00_00_00_01_00_00_00_00;
    localparam logic [`CONV_TAPS*`CONV_COEF_W-1:0] GAUSS_KERN = 72'h01_02_01_02_04_02_01_02_01;

    logic                               clk_i;
    logic                               rstn_i;
    logic                               cfg_valid_i;
    logic [`CONV_TAPS*`CONV_COEF_W-1:0] cfg_coef_i;
    conv_pkg::conv_mode_e               cfg_mode_i;
    logic                               cfg_sat_i;
    logic                               pix_valid_i;
    conv_pkg::pix_t                     pix_i;
    logic                               stall_i;
    logic                               busy_o;
    logic                               out_valid_o;
    conv_pkg::pix_t                     out_pix_o;
    int                                 out_count;
    int                                 fail_count;
    int                                 tb_fails;    // Failures seen outside the checker.
    int                                 tests_run;
    bit                                 timed_out;
    logic [31:0]                        pix_lfsr;
    logic [31:0]                        ctl_lfsr;    // Coefficients, gaps and stalls.
    logic [`CONV_TAPS*`CONV_COEF_W-1:0] rand_kern;

    conv_top i_conv_top (
        .clk_i(clk_i), .rstn_i(rstn_i), .cfg_valid_i(cfg_valid_i), .cfg_coef_i(cfg_coef_i),
        .cfg_mode_i(cfg_mode_i), .cfg_sat_i(cfg_sat_i), .pix_valid_i(pix_valid_i),
        .pix_i(pix_i), .stall_i(stall_i), .busy_o(busy_o), .out_valid_o(out_valid_o),
        .out_pix_o(out_pix_o)
    );

    conv_checker i_conv_checker (
        .clk_i(clk_i), .rstn_i(rstn_i), .cfg_valid_i(cfg_valid_i), .cfg_coef_i(cfg_coef_i),
        .cfg_mode_i(cfg_mode_i), .cfg_sat_i(cfg_sat_i), .pix_valid_i(pix_valid_i),
        .pix_i(pix_i), .stall_i(stall_i), .busy_i(busy_o), .out_valid_i(out_valid_o),
        .out_pix_i(out_pix_o), .out_count_o(out_count), .fail_count_o(fail_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1.
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] take_bits(input bit from_ctl, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (from_ctl) begin
                ctl_lfsr = lfsr_next(ctl_lfsr);
                v = {v[30:0], ctl_lfsr[0]};
            end else begin
                pix_lfsr = lfsr_next(pix_lfsr);
                v = {v[30:0], pix_lfsr[0]};
            end
        end
        return v;
    endfunction

    function automatic conv_pkg::pix_t next_pixel(input bit high_bias);
        logic [31:0] v;
        v = take_bits(1'b0, 8);
        if (high_bias && take_bits(1'b0, 3) != 0) begin
            v[7] = 1'b1;   // Mostly bright, so erosion hits often.
        end
        return v[7:0];
    endfunction

    task automatic reset_dut();
        rstn_i <= 1'b0;
        repeat (8) @(posedge clk_i);
        #2;
        rstn_i <= 1'b1;
        if (out_valid_o !== 1'b0 || busy_o !== 1'b0) begin
            $display("out_valid_o or busy_o is not low right after reset");
            tb_fails++;
        end
    endtask

    task automatic send_frame(input bit gaps, input bit high_bias);
        int             sent;
        int             guard;
        logic           stall;
        logic           valid;
        conv_pkg::pix_t pix;
        sent  = 0;
        guard = 0;
        pix   = next_pixel(high_bias);
        while (sent < FRAME_PIX && guard < 16 * FRAME_PIX) begin
            stall = gaps && (take_bits(1'b1, 2) == 0);
            valid = !gaps || (take_bits(1'b1, 2) != 0);
            stall_i     <= stall;
            pix_valid_i <= valid;
            pix_i       <= valid ? pix : ~pix;   // Idle cycles carry junk.
            @(posedge clk_i);
            #2;
            guard++;
            if (valid && !stall) begin
                sent++;
                if (sent < FRAME_PIX) begin
                    pix = next_pixel(high_bias);
                end
            end
        end
        pix_valid_i <= 1'b0;
        stall_i     <= 1'b0;
        if (sent < FRAME_PIX) begin
            $display("timeout: only %0d of %0d pixels were taken", sent, FRAME_PIX);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_outputs(input int target, input bit gaps);
        int guard;
        guard = 0;
        while (out_count < target && guard < DRAIN_LIMIT) begin
            stall_i <= gaps && (take_bits(1'b1, 2) == 0);
            @(posedge clk_i);
            #2;
            guard++;
        end
        stall_i <= 1'b0;
        if (out_count < target) begin
            $display("timeout: %0d outputs missing at the end of a frame", target - out_count);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input int num, input string name,
                            input logic [`CONV_TAPS*`CONV_COEF_W-1:0] kern,
                            input conv_pkg::conv_mode_e mode, input logic sat,
                            input bit gaps, input bit high_bias);
        int outs_before;
        int fails_before;
        int guard;
        if (!timed_out) begin
            outs_before  = out_count;
            fails_before = fail_count + tb_fails;
            guard        = 0;
            while (busy_o && guard < DRAIN_LIMIT) begin
                @(posedge clk_i);
                #2;
                guard++;
            end
            if (busy_o) begin
                $display("timeout: busy_o stayed high before a new frame");
                timed_out = 1'b1;
            end else begin
                cfg_valid_i <= 1'b1;
                cfg_coef_i  <= kern;
                cfg_mode_i  <= mode;
                cfg_sat_i   <= sat;
                @(posedge clk_i);
                #2;
                cfg_valid_i <= 1'b0;
                send_frame(gaps, high_bias);
            end
            if (!timed_out) begin
                wait_outputs(outs_before + FRAME_PIX, gaps);
            end
            tests_run++;
            $display("test %0d %s: %0d outputs, %0d failures", num, name,
                     out_count - outs_before, fail_count + tb_fails - fails_before);
        end
    endtask

    initial begin
        logic [31:0] bits;
        logic [31:0] frame2_seed;
        rstn_i      = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_coef_i  = '0;
        cfg_mode_i  = conv_pkg::MODE_CONV;
        cfg_sat_i   = 1'b0;
        pix_valid_i = 1'b0;
        pix_i       = '0;
        stall_i     = 1'b0;
        tb_fails    = 0;
        tests_run   = 0;
        timed_out   = 1'b0;
        pix_lfsr    = 32'hba5b5b23;
        ctl_lfsr    = 32'hba5b5b23;
        reset_dut();
        for (int k = 0; k < `CONV_TAPS; k++) begin
            bits = take_bits(1'b1, 8);
            rand_kern[8*k +: 8] = bits[7:0];
        end

        run_test(1, "identity", IDENT_KERN, conv_pkg::MODE_CONV, 1'b1, 1'b0, 1'b0);
        frame2_seed = pix_lfsr;
        run_test(2, "random kernel clipped", rand_kern, conv_pkg::MODE_CONV, 1'b1, 1'b0, 1'b0);
        run_test(3, "random kernel low byte", rand_kern, conv_pkg::MODE_CONV, 1'b0, 1'b0, 1'b0);
        run_test(4, "gaussian", GAUSS_KERN, conv_pkg::MODE_GAUSS, 1'b0, 1'b0, 1'b0);
        run_test(5, "erosion", rand_kern, conv_pkg::MODE_ERODE, 1'b0, 1'b0, 1'b1);
        if (!timed_out) begin
            reset_dut();
            pix_lfsr = frame2_seed;   // Same pixels as test 2.
            run_test(6, "gaps and stalls", rand_kern, conv_pkg::MODE_CONV, 1'b1, 1'b1, 1'b0);
            repeat (8) @(posedge clk_i);
            if (out_count != tests_run * FRAME_PIX) begin
                $display("output count is %0d, expected %0d", out_count, tests_run * FRAME_PIX);
                tb_fails++;
            end
        end

        $display("summary: %0d tests, %0d outputs, %0d failures", tests_run, out_count,
                 fail_count + tb_fails + int'(timed_out));
        if (fail_count == 0 && tb_fails == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verification/conv_checker.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_checker (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               cfg_valid_i,
    input  logic [`CONV_TAPS*`CONV_COEF_W-1:0] cfg_coef_i,
    input  conv_pkg::conv_mode_e               cfg_mode_i,
    input  logic                               cfg_sat_i,
    input  logic                               pix_valid_i,
    input  conv_pkg::pix_t                     pix_i,
    input  logic                               stall_i,
    input  logic                               busy_i,
    input  logic                               out_valid_i,
    input  conv_pkg::pix_t                     out_pix_i,
    output int                                 out_count_o,
    output int                                 fail_count_o
);

    conv_pkg::pix_t       frame_m [`CONV_IMG_H][`CONV_IMG_W];   // Copy of the accepted frame.
    conv_pkg::coef_t      coef_m [`CONV_TAPS];
    conv_pkg::conv_mode_e mode_m;
    logic                 sat_m;
    int                   in_row;
    int                   in_col;
    int                   out_row;
    int                   out_col;
    int                   flush_left;   // Unstalled flush cycles still owed.
    int                   out_count  = 0;
    int                   fail_count = 0;

    assign out_count_o  = out_count;
    assign fail_count_o = fail_count;

    // Expected pixel for centre (r,c), neighbours outside the image read as zero.
    function automatic conv_pkg::pix_t ref_pixel(input int r, input int c);
        int             tap [`CONV_TAPS];
        int             sum;
        bit             all_high;
        int             k;
        conv_pkg::pix_t res;
        sum      = 0;
        all_high = 1'b1;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                k = 3 * (dr + 1) + dc + 1;
                if (r + dr < 0 || r + dr >= `CONV_IMG_H ||
                    c + dc < 0 || c + dc >= `CONV_IMG_W) begin
                    tap[k] = 0;
                end else begin
                    tap[k] = int'(frame_m[r + dr][c + dc]);
                end
            end
        end
        for (k = 0; k < `CONV_TAPS; k++) begin
            if (mode_m == conv_pkg::MODE_GAUSS) begin
                sum += int'($unsigned(coef_m[k])) * tap[k];   // Weights taken as unsigned.
            end else begin
                sum += int'(coef_m[k]) * tap[k];
            end
            all_high &= (tap[k] >= `CONV_ERODE_TH);
        end
        case (mode_m)
            conv_pkg::MODE_GAUSS: begin
                res = conv_pkg::pix_t'((sum >> `CONV_GAUSS_SHIFT) +
                                       ((sum >> (`CONV_GAUSS_SHIFT - 1)) & 1));
            end
            conv_pkg::MODE_ERODE: res = all_high ? 8'd255 : conv_pkg::pix_t'(tap[4]);
            default: begin
                if (sat_m && sum < 0) begin
                    res = 8'd0;
                end else if (sat_m && sum > 255) begin
                    res = 8'd255;
                end else begin
                    res = conv_pkg::pix_t'(sum);   // Low byte.
                end
            end
        endcase
        return res;
    endfunction

    always @(posedge clk_i) begin
        conv_pkg::pix_t expected;
        if (!rstn_i) begin
            for (int k = 0; k < `CONV_TAPS; k++) begin
                coef_m[k] = '0;
            end
            mode_m     = conv_pkg::MODE_CONV;
            sat_m      = 1'b0;
            in_row     = 0;
            in_col     = 0;
            out_row    = 0;
            out_col    = 0;
            flush_left = 0;
        end else begin
            // Busy covers exactly the W+1 unstalled flush cycles after the last pixel.
            if (busy_i !== (flush_left > 0)) begin
                $display("FAIL %0t: busy_o is %0b, expected %0b",
                         $time, busy_i, flush_left > 0);
                fail_count++;
            end
            if (flush_left > 0 && !stall_i) begin
                flush_left--;
            end
            // Output held over a stall is counted in its last cycle only.
            if (out_valid_i && !stall_i) begin
                expected = ref_pixel(out_row, out_col);
                if (out_pix_i !== expected) begin
                    $display("FAIL %0t: pixel (%0d,%0d) is %0d, expected %0d",
                             $time, out_row, out_col, out_pix_i, expected);
                    fail_count++;
                end
                out_count++;
                out_col++;
                if (out_col == `CONV_IMG_W) begin
                    out_col = 0;
                    out_row = (out_row == `CONV_IMG_H - 1) ? 0 : out_row + 1;
                end
            end
            // New settings reach only later outputs.
            if (cfg_valid_i && !stall_i) begin
                for (int k = 0; k < `CONV_TAPS; k++) begin
                    // Tap 0 in the top byte.
                    coef_m[k] = cfg_coef_i[`CONV_COEF_W * (`CONV_TAPS - 1 - k) +: `CONV_COEF_W];
                end
                mode_m = cfg_mode_i;
                sat_m  = cfg_sat_i;
            end
            if (pix_valid_i && !stall_i && !busy_i) begin
                frame_m[in_row][in_col] = pix_i;
                in_col++;
                if (in_col == `CONV_IMG_W) begin
                    in_col = 0;
                    if (in_row == `CONV_IMG_H - 1) begin
                        in_row     = 0;
                        flush_left = `CONV_IMG_W + 1;   // Last pixel of the frame.
                    end else begin
                        in_row = in_row + 1;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/conv_top.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_top (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  logic                                  cfg_valid_i,
    input  logic [`CONV_TAPS*`CONV_COEF_W-1:0]    cfg_coef_i,
    input  conv_pkg::conv_mode_e                  cfg_mode_i,
    input  logic                                  cfg_sat_i,
    input  logic                                  pix_valid_i,
    input  conv_pkg::pix_t                        pix_i,
    input  logic                                  stall_i,
    output logic                                  busy_o,
    output logic                                  out_valid_o,
    output conv_pkg::pix_t                        out_pix_o
);

    logic                               step;
    logic                               flush;
    logic                               win_valid;
    logic                               first_row;
    logic                               last_row;
    logic                               first_col;
    logic                               last_col;
    conv_pkg::pix_t                     top_pix;
    conv_pkg::pix_t                     mid_pix;
    conv_pkg::pix_t [`CONV_TAPS-1:0]    taps;
    logic                               tap_valid;

    frame_scanner i_frame_scanner (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pix_valid_i (pix_valid_i),
        .stall_i     (stall_i),
        .busy_o      (busy_o),
        .step_o      (step),
        .flush_o     (flush),
        .win_valid_o (win_valid),
        .first_row_o (first_row),
        .last_row_o  (last_row),
        .first_col_o (first_col),
        .last_col_o  (last_col)
    );

    line_buffer i_line_buffer (
        .clk_i   (clk_i),
        .step_i  (step),
        .flush_i (flush),
        .pix_i   (pix_i),
        .stall_i (stall_i),
        .top_o   (top_pix),
        .mid_o   (mid_pix)
    );

    // Bottom taps taken during flush are always masked by the row or column flags.
    window_regs i_window_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .stall_i     (stall_i),
        .step_i      (step),
        .top_i       (top_pix),
        .mid_i       (mid_pix),
        .bot_i       (pix_i),
        .win_valid_i (win_valid),
        .first_row_i (first_row),
        .last_row_i  (last_row),
        .first_col_i (first_col),
        .last_col_i  (last_col),
        .tap_o       (taps),
        .tap_valid_o (tap_valid)
    );

    conv_engine i_conv_engine (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .stall_i     (stall_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_coef_i  (cfg_coef_i),
        .cfg_mode_i  (cfg_mode_i),
        .cfg_sat_i   (cfg_sat_i),
        .tap_i       (taps),
        .tap_valid_i (tap_valid),
        .out_valid_o (out_valid_o),
        .out_pix_o   (out_pix_o)
    );

endmodule

//--- rtl/conv_engine.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_engine (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                stall_i,
    input  logic                                cfg_valid_i,
    input  logic [`CONV_TAPS*`CONV_COEF_W-1:0]  cfg_coef_i,
    input  conv_pkg::conv_mode_e                cfg_mode_i,
    input  logic                                cfg_sat_i,
    input  conv_pkg::pix_t [`CONV_TAPS-1:0]     tap_i,
    input  logic                                tap_valid_i,
    output logic                                out_valid_o,
    output conv_pkg::pix_t                      out_pix_o
);

    conv_pkg::coef_t      coef_r [`CONV_TAPS];
    conv_pkg::conv_mode_e mode_r;
    logic                 sat_r;
    conv_pkg::acc_t       sum;
    logic                 all_high;
    conv_pkg::pix_t       result;

    // Configuration, tap 0 sits in the top byte.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < `CONV_TAPS; k++) begin
                coef_r[k] <= '0;
            end
            mode_r <= conv_pkg::MODE_CONV;
            sat_r  <= 1'b0;
        end else if (cfg_valid_i && !stall_i) begin
            for (int k = 0; k < `CONV_TAPS; k++) begin
                coef_r[k] <= cfg_coef_i[(`CONV_TAPS - k) * `CONV_COEF_W - 1 -: `CONV_COEF_W];
            end
            mode_r <= cfg_mode_i;
            sat_r  <= cfg_sat_i;
        end
    end

    // Multiply-accumulate. Pixels are always non-negative.
    always_comb begin
        conv_pkg::acc_t prod;
        sum = '0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            if (mode_r == conv_pkg::MODE_GAUSS) begin
                // Weights read as unsigned. Only bits below the top are used after the shift.
                prod = conv_pkg::acc_t'($unsigned(coef_r[k])) *
                       conv_pkg::acc_t'({1'b0, tap_i[k]});
            end else begin
                prod = conv_pkg::acc_t'(coef_r[k]) * conv_pkg::acc_t'({1'b0, tap_i[k]});
            end
            sum = sum + prod;
        end
    end

    // Mode selection.
    always_comb begin
        all_high = 1'b1;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            if (tap_i[k] < conv_pkg::pix_t'(`CONV_ERODE_TH)) begin
                all_high = 1'b0;
            end
        end

        case (mode_r)
            conv_pkg::MODE_GAUSS: begin
                result = sum[`CONV_GAUSS_SHIFT +: `CONV_PIX_W] +
                         conv_pkg::pix_t'(sum[`CONV_GAUSS_SHIFT-1]);   // Round half up.
            end
            conv_pkg::MODE_ERODE: begin
                result = all_high ? '1 : tap_i[`CONV_TAPS/2];   // Else keep the centre.
            end
            default: begin
                if (sat_r && sum < 0) begin
                    result = '0;
                end else if (sat_r && sum > conv_pkg::acc_t'(8'hff)) begin
                    result = '1;
                end else begin
                    result = sum[`CONV_PIX_W-1:0];   // Low byte when not clipping.
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= tap_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && tap_valid_i) begin
            out_pix_o <= result;
        end
    end

endmodule

//--- rtl/window_regs.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module window_regs (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            stall_i,
    input  logic                            step_i,
    input  conv_pkg::pix_t                  top_i,
    input  conv_pkg::pix_t                  mid_i,
    input  conv_pkg::pix_t                  bot_i,
    input  logic                            win_valid_i,
    input  logic                            first_row_i,
    input  logic                            last_row_i,
    input  logic                            first_col_i,
    input  logic                            last_col_i,
    output conv_pkg::pix_t [`CONV_TAPS-1:0] tap_o,
    output logic                            tap_valid_o
);

    conv_pkg::pix_t win_r [3][3];   // [column][row], column 0 is the left one.
    logic           first_row_r;
    logic           last_row_r;
    logic           first_col_r;
    logic           last_col_r;

    always_ff @(posedge clk_i) begin
        if (step_i && !stall_i) begin
            win_r[0]    <= win_r[1];
            win_r[1]    <= win_r[2];
            win_r[2][0] <= top_i;
            win_r[2][1] <= mid_i;
            win_r[2][2] <= bot_i;
            first_row_r <= first_row_i;   // Flags travel with the new centre.
            last_row_r  <= last_row_i;
            first_col_r <= first_col_i;
            last_col_r  <= last_col_i;
        end
    end

    // One pulse per formed window.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tap_valid_o <= 1'b0;
        end else if (!stall_i) begin
            tap_valid_o <= step_i && win_valid_i;
        end
    end

    // Zero padding outside the image, taps in row-major order.
    always_comb begin
        logic masked;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                masked = (r == 0 && first_row_r) || (r == 2 && last_row_r) ||
                         (c == 0 && first_col_r) || (c == 2 && last_col_r);
                tap_o[3*r + c] = masked ? '0 : win_r[c][r];
            end
        end
    end

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module line_buffer (
    input  logic           clk_i,
    input  logic           step_i,
    input  logic           flush_i,
    input  conv_pkg::pix_t pix_i,
    input  logic           stall_i,
    output conv_pkg::pix_t top_o,
    output conv_pkg::pix_t mid_o
);

    conv_pkg::pix_t row0_mem [`CONV_IMG_W];   // Two rows above the input.
    conv_pkg::pix_t row1_mem [`CONV_IMG_W];   // One row above the input.

    // Rotates once per row of steps; only the W-step period matters,
    // so the starting column is arbitrary once defined.
    conv_pkg::col_t addr_r = '0;

    conv_pkg::pix_t bot_pix;
    logic           wr_en;

    assign wr_en   = step_i && !stall_i;
    assign bot_pix = flush_i ? '0 : pix_i;      // Zero row below the image.

    // Old values leave in the same cycle as the new ones arrive.
    assign top_o = row0_mem[addr_r];
    assign mid_o = row1_mem[addr_r];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            row0_mem[addr_r] <= row1_mem[addr_r];   // Rows move up by one.
            row1_mem[addr_r] <= bot_pix;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            if (addr_r == conv_pkg::col_t'(`CONV_IMG_W - 1)) begin
                addr_r <= '0;
            end else begin
                addr_r <= addr_r + 1'b1;
            end
        end
    end

endmodule

//--- rtl/frame_scanner.sv
`timescale 1ns/10ps

`include "conv_defines.svh"

module frame_scanner (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic pix_valid_i,
    input  logic stall_i,
    output logic busy_o,
    output logic step_o,
    output logic flush_o,
    output logic win_valid_o,
    output logic first_row_o,
    output logic last_row_o,
    output logic first_col_o,
    output logic last_col_o
);

    typedef enum logic [1:0] {
        SCAN_FILL,      // First W+1 steps, centre still before the image.
        SCAN_RUN,
        SCAN_FLUSH      // Self-timed steps after the last pixel.
    } scan_state_e;

    scan_state_e    state_r;
    conv_pkg::col_t in_col_r;
    conv_pkg::row_t in_row_r;
    conv_pkg::col_t c_col_r;   // Centre trails input by one row and one column.
    conv_pkg::row_t c_row_r;
    logic           accept;
    logic           in_col_end;
    logic           in_row_end;
    logic           c_col_end;
    logic           c_row_end;

    assign in_col_end = (in_col_r == conv_pkg::col_t'(`CONV_IMG_W - 1));
    assign in_row_end = (in_row_r == conv_pkg::row_t'(`CONV_IMG_H - 1));
    assign c_col_end  = (c_col_r == conv_pkg::col_t'(`CONV_IMG_W - 1));
    assign c_row_end  = (c_row_r == conv_pkg::row_t'(`CONV_IMG_H - 1));

    assign accept  = pix_valid_i && !stall_i && (state_r != SCAN_FLUSH);
    assign step_o  = accept || (!stall_i && state_r == SCAN_FLUSH);
    assign flush_o = (state_r == SCAN_FLUSH);
    assign busy_o  = (state_r == SCAN_FLUSH);   // Source holds off while flushing.

    assign win_valid_o = (state_r != SCAN_FILL);
    assign first_row_o = (c_row_r == '0);
    assign last_row_o  = c_row_end;
    assign first_col_o = (c_col_r == '0);
    assign last_col_o  = c_col_end;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r  <= SCAN_FILL;
            in_col_r <= '0;
            in_row_r <= '0;
            c_col_r  <= '0;
            c_row_r  <= '0;
        end else if (step_o) begin
            if (accept) begin
                if (in_col_end) begin
                    in_col_r <= '0;
                    in_row_r <= in_row_end ? '0 : in_row_r + 1'b1;
                end else begin
                    in_col_r <= in_col_r + 1'b1;
                end
            end

            // Centre only moves once the window covers real rows.
            if (state_r != SCAN_FILL) begin
                if (c_col_end) begin
                    c_col_r <= '0;
                    c_row_r <= c_row_end ? '0 : c_row_r + 1'b1;
                end else begin
                    c_col_r <= c_col_r + 1'b1;
                end
            end

            case (state_r)
                SCAN_FILL: begin
                    if (in_row_r == conv_pkg::row_t'(1) && in_col_r == '0) begin
                        state_r <= SCAN_RUN;      // Next step centres on (0,0).
                    end
                end
                SCAN_RUN: begin
                    if (in_row_end && in_col_end) begin
                        state_r <= SCAN_FLUSH;
                    end
                end
                SCAN_FLUSH: begin
                    if (c_row_end && c_col_end) begin
                        state_r <= SCAN_FILL;     // Last window formed.
                    end
                end
                default: state_r <= SCAN_FILL;
            endcase
        end
    end

endmodule

//--- rtl/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

    // Engine modes.
    typedef enum logic [1:0] {
        MODE_CONV,      // Signed kernel, optional clipping.
        MODE_GAUSS,     // Unsigned weights, rounded shift.
        MODE_ERODE      // Threshold on all nine taps.
    } conv_mode_e;

    // One pixel.
    typedef logic [`CONV_PIX_W-1:0] pix_t;

    // One kernel weight.
    typedef logic signed [`CONV_COEF_W-1:0] coef_t;

    // Sum of nine signed 8x9 bit products.
    // Worst case is 9 * 128 * 255, which needs 20 bits with sign.
    typedef logic signed [19:0] acc_t;

    // Raster position.
    typedef logic [`CONV_COL_W-1:0] col_t;
    typedef logic [`CONV_ROW_W-1:0] row_t;

endpackage

//--- include/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Image geometry.
`define CONV_IMG_W       320
`define CONV_IMG_H       240
`define CONV_COL_W       9      // Holds 0..319.
`define CONV_ROW_W       8      // Holds 0..239.

// Data path.
`define CONV_PIX_W       8
`define CONV_COEF_W      8      // Signed two's complement.
`define CONV_TAPS        9      // 3x3 window, row major.

// Erosion: a tap counts as white from this level up.
`define CONV_ERODE_TH    128

// Gaussian normalisation, weights 1 2 1 / 2 4 2 / 1 2 1 sum to 16.
`define CONV_GAUSS_SHIFT 4

`endif
